//--- sim.f
src/int_div_pkg.sv
src/int_div_ctrl.sv
src/int_div_dpath.sv
src/int_div_iterative.sv
sim/tb_int_div.sv

//--- Makefile
# Verilator build and run of the iterative divider testbench

TOP = tb_int_div

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, pass if TEST OK is in sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "TEST OK" sim.log && echo "simulation passed" || \
		(echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_int_div.sv
// --------------------
// testbench for the iterative divider, corner and random requests
// with back-pressure, checked against a reference model
// --------------------

`timescale 1ns/1ps

module tb_int_div
  import int_div_pkg::*;
;

  localparam int num_reqs       = 300;
  localparam int num_corners    = 17;
  localparam int timeout_cycles = num_reqs * 80;

  // corner cases, function bit then dividend and divisor
  localparam logic corner_sgn [num_corners] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1
  };
  localparam word_t corner_a [num_corners] = '{
    32'd100, 32'd0, 32'hffff_ffff, 32'hffff_ffff, 32'd3, 32'd1234, 32'd0,
    -32'd100, 32'd100, -32'd100, 32'd100, 32'h8000_0000, 32'h8000_0000,
    -32'd5, 32'd5, 32'd7, 32'd0
  };
  localparam word_t corner_b [num_corners] = '{
    32'd7, 32'd5, 32'hffff_ffff, 32'd1, 32'd10, 32'd0, 32'd0,
    32'd7, -32'd7, -32'd7, 32'd7, 32'hffff_ffff, 32'd1,
    32'd0, 32'd0, -32'd100, -32'd3
  };

  logic    clk;
  logic    reset;
  div_fn_t req_msg_fn;
  word_t   req_msg_a;
  word_t   req_msg_b;
  logic    req_val;
  logic    req_rdy;
  result_t resp_msg_result;
  logic    resp_val;
  logic    resp_rdy;

  // random resp_rdy only after the corner cases
  logic    bp_enable;

  // scoreboard state
  result_t exp_q [$];
  int      cycle_count;
  int      accept_edge;
  int      checked;
  logic    busy;
  logic    resp_seen;
  result_t held_result;

  int_div_iterative i_int_div_iterative (
    .clk             (clk),
    .reset           (reset),
    .req_msg_fn      (req_msg_fn),
    .req_msg_a       (req_msg_a),
    .req_msg_b       (req_msg_b),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_msg_result (resp_msg_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy)
  );

  // --------------------
  // reference model and check
  // --------------------

  // magnitude division, zero divisor gives all ones and the dividend
  function automatic result_t div_ref(input div_fn_t fn, input word_t a, input word_t b);
    logic  neg_a;
    logic  neg_b;
    word_t mag_a;
    word_t mag_b;
    word_t q;
    word_t r;
    neg_a = (fn == div_fn_signed) && a[31];
    neg_b = (fn == div_fn_signed) && b[31];
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    if (mag_b == '0) begin
      q = '1;
      r = mag_a;
    end else begin
      q = mag_a / mag_b;
      r = mag_a % mag_b;
    end
    // quotient sign from both operands, remainder follows the dividend
    if (neg_a != neg_b) begin
      q = -q;
    end
    if (neg_a) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // --------------------
  // clock and timeout
  // --------------------

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout, only %0d of %0d responses after %0d cycles",
               checked, num_reqs, cycle_count);
      $display("TEST FAILED");
      $fatal(1, "run did not finish in time");
    end
  end

  // --------------------
  // stimulus
  // --------------------

  // holds req_val until the accepting edge, then drops it
  task automatic send_request(input div_fn_t fn, input word_t a, input word_t b);
    req_msg_fn = fn;
    req_msg_a  = a;
    req_msg_b  = b;
    req_val    = 1'b1;
    // req_rdy settles right after the edge
    while (!req_rdy) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // consumer side
  initial begin
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (bp_enable) begin
        resp_rdy = ($urandom % 3) != 0;
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] r;
    word_t       a;
    word_t       b;
    div_fn_t     fn;
    void'($urandom(98));
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg_fn  = div_fn_unsigned;
    req_msg_a   = '0;
    req_msg_b   = '0;
    bp_enable   = 1'b0;
    cycle_count = 0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    // fixed corners with resp_rdy held high
    for (int i = 0; i < num_corners; i++) begin
      send_request(corner_sgn[i] ? div_fn_signed : div_fn_unsigned, corner_a[i], corner_b[i]);
    end

    bp_enable = 1'b1;
    for (int i = num_corners; i < num_reqs; i++) begin
      r  = $urandom();
      a  = $urandom();
      b  = $urandom();
      fn = r[0] ? div_fn_signed : div_fn_unsigned;
      // skew some operands toward zero, small and extreme values
      case (r[3:1])
        3'd0: b = '0;
        3'd1: b = {28'd0, r[7:4]};
        3'd2: b = ~{28'd0, r[7:4]};
        3'd3: a = 32'h8000_0000;
        3'd4: a = {16'd0, a[15:0]};
        default: ;
      endcase
      idle_cycles(int'(r[9:8]));
      send_request(fn, a, b);
    end

    wait (checked == num_reqs);
    idle_cycles(40);
    if (exp_q.size() == 0 && checked == num_reqs) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("extra or missing responses, %0d checked, %0d still queued",
               checked, exp_q.size());
      $display("TEST FAILED");
      $fatal(1, "response count wrong");
    end
  end

  // --------------------
  // compare
  // --------------------

  // sampled at negedge, where inputs and outputs are settled for the next edge
  initial begin
    busy      = 1'b0;
    resp_seen = 1'b0;
    checked   = 0;
  end

  always @(negedge clk) begin
    if (!reset) begin
      if (!busy) begin
        check_value(64'(resp_val), 64'd0, "resp_val with no request in flight");
      end else begin
        check_value(64'(req_rdy), 64'd0, "req_rdy high while a division is in flight");
        if (resp_val) begin
          if (!resp_seen) begin
            // resp_val rises 32 edges after the accepting edge
            check_value(64'(cycle_count - accept_edge), 64'(div_steps), "response latency");
            held_result = resp_msg_result;
            resp_seen   = 1'b1;
          end else begin
            check_value(resp_msg_result, held_result, "result changed under back-pressure");
          end
          if (resp_rdy) begin
            if (exp_q.size() == 0) begin
              $display("response transfer with no expected result queued");
              $display("TEST FAILED");
              $fatal(1, "scoreboard empty");
            end
            check_value(resp_msg_result, exp_q.pop_front(), "division result");
            checked   = checked + 1;
            busy      = 1'b0;
            resp_seen = 1'b0;
          end
        end
      end
      // accepting edge is the next posedge
      if (req_val && req_rdy) begin
        exp_q.push_back(div_ref(req_msg_fn, req_msg_a, req_msg_b));
        accept_edge = cycle_count + 1;
        busy        = 1'b1;
      end
    end
  end

endmodule

//--- src/int_div_iterative.sv
// --------------------
// top level of the iterative 32-bit integer divider
// val/rdy request in, remainder and quotient out after a fixed latency
// --------------------

`timescale 1ns/1ps

module int_div_iterative
  import int_div_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  // request side
  input  div_fn_t req_msg_fn,
  input  word_t   req_msg_a,
  input  word_t   req_msg_b,
  input  logic    req_val,
  output logic    req_rdy,

  // response side
  output result_t resp_msg_result,
  output logic    resp_val,
  input  logic    resp_rdy
);

  // --------------------
  // control to datapath
  // --------------------

  // capture operands on the accepting edge
  logic load;

  // one restoring step per edge
  logic step;

  // handshakes and step sequencing
  int_div_ctrl i_int_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // operand registers and the shift-subtract loop
  // result output is combinational from its registers
  int_div_dpath i_int_div_dpath (
    .clk             (clk),
    .reset           (reset),
    .req_msg_fn      (req_msg_fn),
    .req_msg_a       (req_msg_a),
    .req_msg_b       (req_msg_b),
    .load            (load),
    .step            (step),
    .resp_msg_result (resp_msg_result)
  );

endmodule

//--- src/int_div_dpath.sv
// --------------------
// datapath of the iterative divider
// magnitude load, restoring shift-subtract steps and result sign fix
// --------------------

`timescale 1ns/1ps

module int_div_dpath
  import int_div_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  // request operands, sampled on load
  input  div_fn_t req_msg_fn,
  input  word_t   req_msg_a,
  input  word_t   req_msg_b,

  // from control
  input  logic    load,
  input  logic    step,

  // signed result, valid while control holds resp_val
  output result_t resp_msg_result
);

  // --------------------
  // state
  // --------------------

  // remainder in the upper half, quotient bits shift in at the bottom
  result_t rq_reg;

  // divisor magnitude
  word_t   divisor_reg;

  // function and raw operand signs of the request in flight
  div_fn_t fn_reg;
  logic    sign_a_reg;
  logic    sign_b_reg;

  // --------------------
  // load side
  // --------------------

  // operand needs negating only in signed mode
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  always_comb begin
    a_neg = (req_msg_fn == div_fn_signed) && req_msg_a[31];
    b_neg = (req_msg_fn == div_fn_signed) && req_msg_b[31];
  end

  // two's complement magnitude
  // most negative value maps onto itself, which is its correct unsigned magnitude
  always_comb begin
    a_mag = a_neg ? (~req_msg_a + 32'd1) : req_msg_a;
    b_mag = b_neg ? (~req_msg_b + 32'd1) : req_msg_b;
  end

  // --------------------
  // one restoring step
  // --------------------

  // partial remainder after the shift
  // 33 bits since the bit shifted out of the upper half still counts
  logic [32:0] rem_shift;

  // trial difference, msb is the borrow
  logic [33:0] diff;

  // next quotient bit and next remainder
  logic        q_bit;
  word_t       rem_next;
  result_t     rq_next;

  always_comb begin
    rem_shift = rq_reg[63:31];
    diff      = {1'b0, rem_shift} - {2'b00, divisor_reg};
  end

  // no borrow means the divisor fits
  always_comb begin
    q_bit = ~diff[33];
  end

  // restore by keeping the shifted value when the divisor did not fit
  // either way the kept remainder is below the divisor, so 32 bits suffice
  always_comb begin
    if (q_bit) begin
      rem_next = diff[31:0];
    end else begin
      rem_next = rem_shift[31:0];
    end
  end

  // lower half shifts left, new quotient bit enters at bit 0
  always_comb begin
    rq_next = {rem_next, rq_reg[30:0], q_bit};
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg      <= '0;
      divisor_reg <= '0;
      fn_reg      <= div_fn_unsigned;
      sign_a_reg  <= 1'b0;
      sign_b_reg  <= 1'b0;
    end else if (load) begin
      // dividend magnitude starts in the lower half, remainder cleared
      rq_reg      <= {32'd0, a_mag};
      divisor_reg <= b_mag;
      fn_reg      <= req_msg_fn;
      sign_a_reg  <= req_msg_a[31];
      sign_b_reg  <= req_msg_b[31];
    end else if (step) begin
      rq_reg      <= rq_next;
    end
  end

  // --------------------
  // result sign fix
  // --------------------

  word_t quot_mag;
  word_t rem_mag;
  logic  neg_quot;
  logic  neg_rem;
  word_t quot_out;
  word_t rem_out;

  always_comb begin
    quot_mag = rq_reg[31:0];
    rem_mag  = rq_reg[63:32];
  end

  // quotient negative when exactly one operand is negative
  // remainder follows the dividend
  always_comb begin
    neg_quot = (fn_reg == div_fn_signed) && (sign_a_reg ^ sign_b_reg);
    neg_rem  = (fn_reg == div_fn_signed) && sign_a_reg;
  end

  // zero divisor needs nothing extra, same rule on all-ones quotient
  always_comb begin
    quot_out = neg_quot ? (~quot_mag + 32'd1) : quot_mag;
    rem_out  = neg_rem ? (~rem_mag + 32'd1) : rem_mag;
  end

  assign resp_msg_result = {rem_out, quot_out};

  // --------------------
  // checks
  // --------------------

  // control never asks for a load in the middle of a division
  a_no_load_during_step : assert property (
    @(posedge clk) disable iff (reset)
    !(load && step)
  ) else $error("load and step high in the same cycle");

endmodule

//--- src/int_div_ctrl.sv
// --------------------
// control FSM of the iterative divider
// sequences load, the fixed run of steps and the response handshake
// --------------------

`timescale 1ns/1ps

module int_div_ctrl
  import int_div_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // to datapath
  output logic load,
  output logic step
);

  // --------------------
  // state and counter
  // --------------------

  div_state_t  state;
  div_state_t  state_next;
  step_count_t count;
  step_count_t count_next;

  // handshake events
  logic req_go;
  logic resp_go;

  // counter sits on the final step
  logic last_step;

  always_comb begin
    req_go    = req_val && req_rdy;
    resp_go   = resp_val && resp_rdy;
    last_step = (count == step_count_t'(div_steps - 1));
  end

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      st_idle: begin
        // accepting edge clears the counter
        if (req_go) begin
          state_next = st_calc;
          count_next = '0;
        end
      end
      st_calc: begin
        // counter wraps back to zero on the last step
        count_next = count + step_count_t'(1);
        if (last_step) begin
          state_next = st_done;
        end
      end
      st_done: begin
        // hold the result until the consumer takes it
        if (resp_go) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
        count_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  // --------------------
  // outputs
  // --------------------

  // one division in flight, so ready only when idle
  always_comb begin
    req_rdy  = (state == st_idle);
    resp_val = (state == st_done);
  end

  // datapath strobes
  always_comb begin
    load = req_go;
    step = (state == st_calc);
  end

  // --------------------
  // checks
  // --------------------

  // request and response sides never open together
  a_rdy_val_exclusive : assert property (
    @(posedge clk) disable iff (reset)
    !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  // counter is left at zero whenever a division ends
  a_idle_count_zero : assert property (
    @(posedge clk) disable iff (reset)
    (state == st_idle) |-> (count == '0)
  ) else $error("step counter not zero in idle");

  // fixed latency from load to response
  a_fixed_steps : assert property (
    @(posedge clk) disable iff (reset)
    load |=> step [*div_steps] ##1 (resp_val && !step)
  ) else $error("response not reached after exactly the expected steps");

endmodule

//--- src/int_div_pkg.sv
// --------------------
// shared types and constants for the iterative integer divider
// imported by wildcard into each divider module and the testbench
// --------------------

package int_div_pkg;

  // operand, quotient or remainder
  typedef logic [31:0] word_t;

  // response word, remainder in the upper half and quotient in the lower half
  typedef logic [63:0] result_t;

  // request function bit
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_t;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } div_state_t;

  // counts the division steps, wraps after the last one
  typedef logic [4:0] step_count_t;

  // one restoring step per quotient bit
  localparam int div_steps = 32;

endpackage
